//--- flist.f
verilog/cp0Pkg.sv
verilog/commitPkg.sv
verilog/excClassify.sv
verilog/intSource.sv
verilog/cp0Regs.sv
verilog/excUnit.sv
testbench/excUnit_assert.sv
testbench/excUnitTb.sv

//--- run.sh
#!/bin/sh
# Build and run the exception unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --top-module excUnitTb \
    -f flist.f -o simExcUnit > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simExcUnit > "$SIM_LOG" 2>&1
simStatus=$?
cat "$SIM_LOG"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "tests failed" "$SIM_LOG"; then
    exit 1
fi
exit 0

//--- testbench/excUnitGolden.txt
# op addr wdata pc dslot faults(fetch ri sys ov store) hwLines hold(decimal)
# then expected redirect target rdata, every other column hex
1 0e 12345678 00000100 0 00 00 0 0 00000000 00000000
2 0e 00000000 00000104 0 00 00 3 0 00000000 12345678
1 0b 0000abcd 00000108 0 00 00 0 0 00000000 00000000
2 0b 00000000 0000010c 0 00 00 0 0 00000000 0000abcd
1 0c 0000fc00 00000110 0 00 00 0 0 00000000 00000000
2 0c 00000000 00000114 0 00 00 0 0 00000000 0000fc00
2 1f 00000000 00000118 0 00 00 0 0 00000000 00000000
2 09 00000000 0000011c 0 00 00 0 0 00000000 00000007
0 00 00000000 00000200 0 10 00 2 1 00004180 00000000
2 0d 00000000 00000204 0 00 00 0 0 00000000 00000010
3 00 00000000 00000208 0 00 00 0 1 00000200 00000000
0 00 00000000 00000300 0 08 00 0 1 00004180 00000000
2 0d 00000000 00000304 0 00 00 0 0 00000000 00000028
3 00 00000000 00000308 0 00 00 0 1 00000300 00000000
0 00 00000000 00000310 0 04 00 0 1 00004180 00000000
2 0d 00000000 00000314 0 00 00 0 0 00000000 00000020
3 00 00000000 00000318 0 00 00 0 1 00000310 00000000
0 00 00000000 00000320 0 02 00 0 1 00004180 00000000
2 0d 00000000 00000324 0 00 00 0 0 00000000 00000030
3 00 00000000 00000328 0 00 00 0 1 00000320 00000000
0 00 00000000 00000330 0 01 00 0 1 00004180 00000000
2 0d 00000000 00000334 0 00 00 0 0 00000000 00000014
0 00 00000000 00000338 0 08 00 0 0 00000000 00000000
3 00 00000000 0000033c 0 00 00 0 1 00000330 00000000
0 00 00000000 00000340 0 0f 00 0 1 00004180 00000000
2 0d 00000000 00000344 0 00 00 0 0 00000000 00000028
3 00 00000000 00000348 0 00 00 0 1 00000340 00000000
0 00 00000000 00000350 1 1f 00 0 1 00004180 00000000
2 0d 00000000 00000354 0 00 00 0 0 00000000 80000010
3 00 00000000 00000358 0 00 00 0 1 0000034c 00000000
0 00 00000000 00000400 0 00 01 0 0 00000000 00000000
1 0c 0000fc01 00000404 0 00 01 0 0 00000000 00000000
0 00 00000000 00000408 0 08 01 2 1 00004180 00000000
2 0d 00000000 0000040c 0 00 01 0 0 00000000 00000400
0 00 00000000 00000410 0 00 01 0 0 00000000 00000000
3 00 00000000 00000414 0 00 01 0 1 00000408 00000000
0 00 00000000 00000408 0 00 00 0 0 00000000 00000000
1 0b 00000003 0000040c 0 00 00 0 0 00000000 00000000
1 09 00000000 00000410 0 00 00 0 0 00000000 00000000
0 00 00000000 00000500 0 00 00 0 0 00000000 00000000
0 00 00000000 00000504 0 00 00 0 0 00000000 00000000
2 09 00000000 00000508 0 00 00 0 0 00000000 00000002
0 00 00000000 0000050c 0 00 00 4 1 00004180 00000000
2 0d 00000000 00000510 0 00 00 0 0 00000000 00008000
1 0b 00000100 00000514 0 00 00 0 0 00000000 00000000
2 0d 00000000 00000518 0 00 00 0 0 00000000 00000000
3 00 00000000 0000051c 0 00 00 0 1 0000050c 00000000
0 00 00000000 00000510 0 00 00 5 0 00000000 00000000

//--- testbench/excUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module excUnitTb;
    import commitPkg::*;

    localparam logic [DATA_W-1:0] VECTOR = 32'h0000_4180;

    // One retired instruction and its expected result
    typedef struct packed {
        logic [1:0]        op;
        logic [4:0]        addr;
        logic [DATA_W-1:0] wdata;
        logic [DATA_W-1:0] pc;
        logic              delaySlot;
        logic [4:0]        faults;
        logic [4:0]        hw;
        logic [31:0]       hold;
        logic              redirect;
        logic [DATA_W-1:0] target;
        logic [DATA_W-1:0] rdata;
    } goldenLineT;

    logic                  clk;
    logic                  reset;
    logic                  inValid;
    logic                  inReady;
    commitOpT              op;
    logic [REG_ADDR_W-1:0] regAddr;
    logic [DATA_W-1:0]     wdata;
    logic [DATA_W-1:0]     pc;
    logic                  inDelaySlot;
    logic                  faultFetch;
    logic                  faultRI;
    logic                  faultSys;
    logic                  faultOv;
    logic                  faultStore;
    logic [4:0]            hwLines;
    logic                  outValid;
    logic                  outReady;
    logic                  redirect;
    logic [DATA_W-1:0]     target;
    logic [DATA_W-1:0]     rdata;

    goldenLineT goldenTable[$];
    int         cycleCount = 0;
    int         cycleLimit = 0;

    excUnit #(
        .EXC_VECTOR (VECTOR)
    ) DUT (
        .clk         (clk),
        .reset       (reset),
        .inValid     (inValid),
        .inReady     (inReady),
        .op          (op),
        .regAddr     (regAddr),
        .wdata       (wdata),
        .pc          (pc),
        .inDelaySlot (inDelaySlot),
        .faultFetch  (faultFetch),
        .faultRI     (faultRI),
        .faultSys    (faultSys),
        .faultOv     (faultOv),
        .faultStore  (faultStore),
        .hwLines     (hwLines),
        .outValid    (outValid),
        .outReady    (outReady),
        .redirect    (redirect),
        .target      (target),
        .rdata       (rdata)
    );

    ////////////////////////////////////////////////////////////
    // Clock and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Limit is known once the table is loaded
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Timeout, the run went past %0d cycles", cycleLimit);
            $display("tests failed");
            $fatal(1);
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic checkBit(int idx, string name, logic actual, logic expected);
        assert (actual === expected) else begin
            $display("[FAIL] line %0d %s expected %h got %h", idx, name, expected, actual);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic checkWord(int idx, string name, logic [31:0] actual, logic [31:0] expected);
        assert (actual === expected) else begin
            $display("[FAIL] line %0d %s expected %h got %h", idx, name, expected, actual);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic checkResult(int idx, goldenLineT g);
        checkBit(idx, "outValid", outValid, 1'b1);
        checkBit(idx, "redirect", redirect, g.redirect);
        checkWord(idx, "target", target, g.target);
        checkWord(idx, "rdata", rdata, g.rdata);
    endtask

    ////////////////////////////////////////////////////////////
    // Golden table
    ////////////////////////////////////////////////////////////

    task automatic readGolden();
        int          fd;
        int          got;
        string       text;
        logic [31:0] v[11];
        goldenLineT  g;
        fd = $fopen("testbench/excUnitGolden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file");
            $display("tests failed");
            $fatal(1);
        end
        while ($fgets(text, fd) != 0) begin
            // Skip comments and blank lines
            if (text.len() < 2 || text[0] == "#") continue;
            got = $sscanf(text, "%h %h %h %h %h %h %h %d %h %h %h", v[0], v[1], v[2],
                          v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
            if (got != 11) begin
                $display("Golden file line has %0d fields instead of 11", got);
                $display("tests failed");
                $fatal(1);
            end
            g = '{v[0][1:0], v[1][4:0], v[2], v[3], v[4][0], v[5][4:0], v[6][4:0],
                  v[7], v[8][0], v[9], v[10]};
            goldenTable.push_back(g);
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////
    // One instruction through both handshakes
    ////////////////////////////////////////////////////////////

    // Called at a rising edge while the previous result, if any, is stalled
    // Returns at a rising edge with this result still stalled
    task automatic runLine(int idx);
        goldenLineT g;
        g = goldenTable[idx];
        inValid     <= 1'b1;
        op          <= commitOpT'(g.op);
        regAddr     <= g.addr;
        wdata       <= g.wdata;
        pc          <= g.pc;
        inDelaySlot <= g.delaySlot;
        faultFetch  <= g.faults[4];
        faultRI     <= g.faults[3];
        faultSys    <= g.faults[2];
        faultOv     <= g.faults[1];
        faultStore  <= g.faults[0];
        hwLines     <= g.hw;
        if (idx > 0) begin
            // Slot full, the instruction has to wait
            @(negedge clk);
            checkBit(idx, "inReady", inReady, 1'b0);
            checkResult(idx - 1, goldenTable[idx - 1]);
            @(posedge clk);
            outReady <= 1'b1;
        end
        // Previous result drains on the edge that takes this one
        @(negedge clk);
        while (!inReady) begin
            @(negedge clk);
        end
        @(posedge clk);
        inValid  <= 1'b0;
        outReady <= 1'b0;
        @(negedge clk);
        checkResult(idx, g);
        // Back-pressure, result must sit still
        repeat (g.hold) begin
            @(posedge clk);
            @(negedge clk);
            checkBit(idx, "inReady", inReady, 1'b0);
            checkResult(idx, g);
        end
        @(posedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        reset       = 1'b1;
        inValid     = 1'b0;
        op          = opAlu;
        regAddr     = '0;
        wdata       = '0;
        pc          = '0;
        inDelaySlot = 1'b0;
        faultFetch  = 1'b0;
        faultRI     = 1'b0;
        faultSys    = 1'b0;
        faultOv     = 1'b0;
        faultStore  = 1'b0;
        hwLines     = '0;
        outReady    = 1'b0;
        readGolden();
        if (goldenTable.size() == 0) begin
            $display("Golden file holds no instructions");
            $display("tests failed");
            $fatal(1);
        end
        // Hold cycles plus handshake slack per line
        foreach (goldenTable[i]) begin
            cycleLimit += int'(goldenTable[i].hold) + 4;
        end
        cycleLimit += 100;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkBit(-1, "outValid", outValid, 1'b0);
        checkBit(-1, "redirect", redirect, 1'b0);
        @(posedge clk);
        foreach (goldenTable[i]) begin
            runLine(i);
        end
        // Last result leaves and nothing follows it
        outReady <= 1'b1;
        @(posedge clk);
        outReady <= 1'b0;
        @(negedge clk);
        checkBit(goldenTable.size() - 1, "outValid", outValid, 1'b0);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/excUnit_assert.sv
`timescale 1ns/1ps
`default_nettype none

module excUnitAssert (
    input logic                         clk,
    input logic                         reset,
    input logic                         inValid,
    input logic                         inReady,
    input logic [commitPkg::DATA_W-1:0] pc,
    input logic                         outValid,
    input logic                         outReady,
    input logic                         redirect,
    input logic [commitPkg::DATA_W-1:0] target,
    input logic [commitPkg::DATA_W-1:0] rdata,
    input logic                         exl
);

    ////////////////////////////////////////////////////////////
    // Handshake rules
    ////////////////////////////////////////////////////////////

    // Pending instruction stays put until taken
    inHold: assert property (@(posedge clk) disable iff (reset)
        inValid && !inReady |=> inValid && $stable(pc))
        else $error("input valid dropped or changed before transfer");

    // Stalled result is frozen
    outHold: assert property (@(posedge clk) disable iff (reset)
        outValid && !outReady |=> outValid && $stable(redirect) && $stable(target)
            && $stable(rdata))
        else $error("output changed while stalled");

    // No room, no accept
    stallBlocks: assert property (@(posedge clk) disable iff (reset)
        outValid && !outReady |-> !inReady)
        else $error("inReady high while output stalled");

    // Clean state out of reset
    resetState: assert property (@(posedge clk)
        reset |=> !outValid && !redirect && !exl)
        else $error("output slot or EXL not cleared by reset");

endmodule

bind cp0Regs excUnitAssert uAssert (
    .clk      (clk),
    .reset    (reset),
    .inValid  (inValid),
    .inReady  (inReady),
    .pc       (pc),
    .outValid (outValid),
    .outReady (outReady),
    .redirect (redirect),
    .target   (target),
    .rdata    (rdata),
    .exl      (exl)
);

`default_nettype wire

//--- verilog/commitPkg.sv
`default_nettype none

package commitPkg;

    ////////////////////////////////////////////////////////////
    // Commit stream opcodes
    ////////////////////////////////////////////////////////////

    // What the retiring instruction asks of coprocessor 0
    // Plain instruction with no coprocessor effect
    // Move to coprocessor register
    // Move from coprocessor register
    // Return from exception
    typedef enum logic [1:0] {
        opAlu  = 2'd0,
        opMtc0 = 2'd1,
        opMfc0 = 2'd2,
        opEret = 2'd3
    } commitOpT;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    // Datapath and address width
    localparam int DATA_W = 32;

    // Coprocessor register number width
    localparam int REG_ADDR_W = 5;

endpackage

`default_nettype wire

//--- verilog/cp0Pkg.sv
`default_nettype none

package cp0Pkg;

    ////////////////////////////////////////////////////////////
    // Exception codes
    ////////////////////////////////////////////////////////////

    // Architectural values as they appear in Cause.ExcCode
    typedef enum logic [4:0] {
        excInt  = 5'd0,
        excAdEL = 5'd4,
        excAdES = 5'd5,
        excSys  = 5'd8,
        excRI   = 5'd10,
        excOv   = 5'd12
    } excCodeT;

    ////////////////////////////////////////////////////////////
    // Register numbers and field positions
    ////////////////////////////////////////////////////////////

    // Coprocessor 0 register numbers used by mtc0 and mfc0
    localparam logic [4:0] REG_COUNT   = 5'd9;
    localparam logic [4:0] REG_COMPARE = 5'd11;
    localparam logic [4:0] REG_STATUS  = 5'd12;
    localparam logic [4:0] REG_CAUSE   = 5'd13;
    localparam logic [4:0] REG_EPC     = 5'd14;

    // Status bits
    localparam int STATUS_IE    = 0;
    localparam int STATUS_EXL   = 1;
    localparam int STATUS_IM_LO = 10;
    localparam int STATUS_IM_HI = 15;

    // Cause bits
    localparam int CAUSE_BD     = 31;
    localparam int CAUSE_IP_LO  = 10;
    localparam int CAUSE_IP_HI  = 15;
    localparam int CAUSE_EXC_LO = 2;
    localparam int CAUSE_EXC_HI = 6;

endpackage

`default_nettype wire

//--- verilog/cp0Regs.sv
`timescale 1ns/1ps
`default_nettype none

module cp0Regs #(
    parameter logic [commitPkg::DATA_W-1:0] EXC_VECTOR = 32'h0000_4180
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             inValid,
    output logic                             inReady,
    input  commitPkg::commitOpT              op,
    input  logic [commitPkg::REG_ADDR_W-1:0] regAddr,
    input  logic [commitPkg::DATA_W-1:0]     wdata,
    input  logic [commitPkg::DATA_W-1:0]     pc,
    input  logic                             inDelaySlot,
    input  cp0Pkg::excCodeT                  excCode,
    input  logic                             excHit,
    input  logic [5:0]                       pendingIp,
    input  logic [commitPkg::DATA_W-1:0]     count,
    input  logic [commitPkg::DATA_W-1:0]     compare,
    output logic                             accept,
    output logic                             taken,
    output logic                             outValid,
    input  logic                             outReady,
    output logic                             redirect,
    output logic [commitPkg::DATA_W-1:0]     target,
    output logic [commitPkg::DATA_W-1:0]     rdata
);
    import cp0Pkg::*;
    import commitPkg::*;

    logic [DATA_W-1:0] status;
    logic              causeBd;
    logic [5:0]        causeIp;
    excCodeT           causeExc;
    logic [DATA_W-1:0] causeWord;
    logic [DATA_W-1:0] epc;
    logic              ie;
    logic              exl;
    logic [5:0]        im;
    logic              intReq;
    logic              excReq;
    logic              retire;
    logic [DATA_W-1:0] readData;
    logic              nextRedirect;
    logic [DATA_W-1:0] nextTarget;
    logic [DATA_W-1:0] nextRdata;

    ////////////////////////////////////////////////////////////
    // Handshake and take decision
    ////////////////////////////////////////////////////////////

    // Slot free or draining this cycle
    assign inReady = !outValid || outReady;
    assign accept  = inValid && inReady;

    assign ie  = status[STATUS_IE];
    assign exl = status[STATUS_EXL];
    assign im  = status[STATUS_IM_HI:STATUS_IM_LO];

    // Both requests are masked while a handler runs
    assign intReq = !exl && ie && |(pendingIp & im);
    assign excReq = !exl && excHit;

    assign taken  = accept && (intReq || excReq);
    assign retire = accept && !taken;

    ////////////////////////////////////////////////////////////
    // Status, Cause, EPC
    ////////////////////////////////////////////////////////////

    // Take sets EXL, eret clears it, mtc0 replaces the word
    always_ff @(posedge clk) begin
        if (reset) begin
            status <= '0;
        end else if (taken) begin
            status[STATUS_EXL] <= 1'b1;
        end else if (retire && (op == opEret)) begin
            status[STATUS_EXL] <= 1'b0;
        end else if (retire && (op == opMtc0) && (regAddr == REG_STATUS)) begin
            status <= wdata;
        end
    end

    // IP mirrors the pending lines every cycle
    // Interrupt beats any fault for the code
    always_ff @(posedge clk) begin
        if (reset) begin
            causeBd  <= 1'b0;
            causeIp  <= '0;
            causeExc <= excInt;
        end else begin
            causeIp <= pendingIp;
            if (taken) begin
                causeBd  <= inDelaySlot;
                causeExc <= intReq ? excInt : excCode;
            end
        end
    end

    // Delay slot faults restart at the branch
    always_ff @(posedge clk) begin
        if (reset) begin
            epc <= '0;
        end else if (taken) begin
            epc <= inDelaySlot ? (pc - DATA_W'(4)) : pc;
        end else if (retire && (op == opMtc0) && (regAddr == REG_EPC)) begin
            epc <= wdata;
        end
    end

    // Unused Cause bits read as zero
    always_comb begin
        causeWord                             = '0;
        causeWord[CAUSE_BD]                   = causeBd;
        causeWord[CAUSE_IP_HI:CAUSE_IP_LO]    = causeIp;
        causeWord[CAUSE_EXC_HI:CAUSE_EXC_LO]  = causeExc;
    end

    ////////////////////////////////////////////////////////////
    // Result
    ////////////////////////////////////////////////////////////

    // mfc0 source select
    always_comb begin
        case (regAddr)
            REG_STATUS:  readData = status;
            REG_CAUSE:   readData = causeWord;
            REG_EPC:     readData = epc;
            REG_COUNT:   readData = count;
            REG_COMPARE: readData = compare;
            default:     readData = '0;
        endcase
    end

    always_comb begin
        nextRedirect = 1'b0;
        nextTarget   = '0;
        nextRdata    = '0;
        if (intReq || excReq) begin
            // Preempted, go to the handler
            nextRedirect = 1'b1;
            nextTarget   = EXC_VECTOR;
        end else begin
            case (op)
                opEret: begin
                    nextRedirect = 1'b1;
                    nextTarget   = epc;
                end
                opMfc0:        nextRdata = readData;
                opAlu, opMtc0: nextRdata = '0;
                default:       nextRdata = '0;
            endcase
        end
    end

    // Single result slot
    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
            redirect <= 1'b0;
        end else if (accept) begin
            outValid <= 1'b1;
            redirect <= nextRedirect;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            target <= nextTarget;
            rdata  <= nextRdata;
        end
    end

endmodule

`default_nettype wire

//--- verilog/excClassify.sv
`timescale 1ns/1ps
`default_nettype none

module excClassify (
    input  logic            faultFetch,
    input  logic            faultRI,
    input  logic            faultSys,
    input  logic            faultOv,
    input  logic            faultStore,
    output cp0Pkg::excCodeT excCode,
    output logic            excHit
);
    import cp0Pkg::*;

    ////////////////////////////////////////////////////////////
    // Fault detection
    ////////////////////////////////////////////////////////////

    // Any flag at all means a synchronous exception
    assign excHit = faultFetch | faultRI | faultSys | faultOv | faultStore;

    ////////////////////////////////////////////////////////////
    // Fixed priority encoder
    ////////////////////////////////////////////////////////////

    // Earliest pipeline fault wins
    // Fetch address error comes from IF, so it is checked first
    // Decode faults next, then execute, then memory
    always_comb begin
        if (faultFetch) begin
            // Misaligned or bad instruction fetch
            excCode = excAdEL;
        end else if (faultRI) begin
            // Unknown opcode
            excCode = excRI;
        end else if (faultSys) begin
            // Syscall instruction
            excCode = excSys;
        end else if (faultOv) begin
            // Signed arithmetic overflow
            excCode = excOv;
        end else if (faultStore) begin
            // Misaligned store address
            excCode = excAdES;
        end else begin
            // Nothing to report
            // Code value is don't care when excHit is low
            excCode = excInt;
        end
    end

endmodule

`default_nettype wire

//--- verilog/excUnit.sv
`timescale 1ns/1ps
`default_nettype none

module excUnit #(
    parameter logic [commitPkg::DATA_W-1:0] EXC_VECTOR = 32'h0000_4180
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             inValid,
    output logic                             inReady,
    input  commitPkg::commitOpT              op,
    input  logic [commitPkg::REG_ADDR_W-1:0] regAddr,
    input  logic [commitPkg::DATA_W-1:0]     wdata,
    input  logic [commitPkg::DATA_W-1:0]     pc,
    input  logic                             inDelaySlot,
    input  logic                             faultFetch,
    input  logic                             faultRI,
    input  logic                             faultSys,
    input  logic                             faultOv,
    input  logic                             faultStore,
    input  logic [4:0]                       hwLines,
    output logic                             outValid,
    input  logic                             outReady,
    output logic                             redirect,
    output logic [commitPkg::DATA_W-1:0]     target,
    output logic [commitPkg::DATA_W-1:0]     rdata
);
    import cp0Pkg::*;
    import commitPkg::*;

    excCodeT           excCode;
    logic              excHit;
    logic [5:0]        pendingIp;
    logic [DATA_W-1:0] count;
    logic [DATA_W-1:0] compare;
    logic              accept;
    logic              taken;

    ////////////////////////////////////////////////////////////
    // Parallel sources
    ////////////////////////////////////////////////////////////

    // Synchronous faults of the committing instruction
    excClassify uClassify (
        .faultFetch (faultFetch),
        .faultRI    (faultRI),
        .faultSys   (faultSys),
        .faultOv    (faultOv),
        .faultStore (faultStore),
        .excCode    (excCode),
        .excHit     (excHit)
    );

    // Timer and external lines
    intSource uIntSource (
        .clk       (clk),
        .reset     (reset),
        .accept    (accept),
        .taken     (taken),
        .op        (op),
        .regAddr   (regAddr),
        .wdata     (wdata),
        .hwLines   (hwLines),
        .count     (count),
        .compare   (compare),
        .pendingIp (pendingIp)
    );

    ////////////////////////////////////////////////////////////
    // Decision and result
    ////////////////////////////////////////////////////////////

    cp0Regs #(
        .EXC_VECTOR (EXC_VECTOR)
    ) uCp0Regs (
        .clk         (clk),
        .reset       (reset),
        .inValid     (inValid),
        .inReady     (inReady),
        .op          (op),
        .regAddr     (regAddr),
        .wdata       (wdata),
        .pc          (pc),
        .inDelaySlot (inDelaySlot),
        .excCode     (excCode),
        .excHit      (excHit),
        .pendingIp   (pendingIp),
        .count       (count),
        .compare     (compare),
        .accept      (accept),
        .taken       (taken),
        .outValid    (outValid),
        .outReady    (outReady),
        .redirect    (redirect),
        .target      (target),
        .rdata       (rdata)
    );

endmodule

`default_nettype wire

//--- verilog/intSource.sv
`timescale 1ns/1ps
`default_nettype none

module intSource (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             accept,
    input  logic                             taken,
    input  commitPkg::commitOpT              op,
    input  logic [commitPkg::REG_ADDR_W-1:0] regAddr,
    input  logic [commitPkg::DATA_W-1:0]     wdata,
    input  logic [4:0]                       hwLines,
    output logic [commitPkg::DATA_W-1:0]     count,
    output logic [commitPkg::DATA_W-1:0]     compare,
    output logic [5:0]                       pendingIp
);
    import cp0Pkg::*;
    import commitPkg::*;

    logic              retire;
    logic              countWrite;
    logic              compareWrite;
    logic [DATA_W-1:0] countInc;
    logic              timerFlag;

    // Instruction accepted and not preempted
    assign retire = accept && !taken;

    // Coprocessor writes to the timer pair
    assign countWrite   = retire && (op == opMtc0) && (regAddr == REG_COUNT);
    assign compareWrite = retire && (op == opMtc0) && (regAddr == REG_COMPARE);

    assign countInc = count + DATA_W'(1);

    ////////////////////////////////////////////////////////////
    // Retire driven timer
    ////////////////////////////////////////////////////////////

    // One tick per completed instruction
    // Software load of Count takes precedence over the tick
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (countWrite) begin
            count <= wdata;
        end else if (retire) begin
            count <= countInc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare <= '0;
        end else if (compareWrite) begin
            compare <= wdata;
        end
    end

    // Sticky match flag
    // Compare of zero disables the timer
    always_ff @(posedge clk) begin
        if (reset) begin
            timerFlag <= 1'b0;
        end else if (compareWrite) begin
            timerFlag <= 1'b0;
        end else if (retire && !countWrite && (compare != '0) && (countInc == compare)) begin
            timerFlag <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Pending vector
    ////////////////////////////////////////////////////////////

    // Timer on IP7, hardware lines below it
    assign pendingIp = {timerFlag, hwLines};

endmodule

`default_nettype wire
